// ==== source/flash_config.svh ====
// Opcodes, chip-select gap, poll limit and read constants
// for the serial NOR flash programmer

`ifndef FLASH_CONFIG_SVH
`define FLASH_CONFIG_SVH

// ====================
// Flash opcodes
// ====================
`define FLASH_CMD_WREN      8'h06
`define FLASH_CMD_WRDI      8'h04
`define FLASH_CMD_RDSR1     8'h05
`define FLASH_CMD_PP        8'h02
`define FLASH_CMD_SE        8'h20
`define FLASH_CMD_BE32      8'h52
`define FLASH_CMD_BE64      8'hD8
`define FLASH_CMD_RDID      8'h9F

// Cycles with chip select high between chained transactions
`define FLASH_CS_GAP        11
// Status re-reads allowed before a timeout
`define FLASH_POLL_LIMIT    65535
`define FLASH_DUMMY_BYTE    8'hFF
`define FLASH_ID_BYTES      3

`endif

// ==== source/flash_pkg.sv ====
// Types shared by the flash programmer: operation and state enums,
// vector typedefs, request and phase structs
`default_nettype none

package flash_pkg;

    typedef logic [7:0]  flash_byte_t;
    typedef logic [23:0] flash_addr_t;
    // Page byte count, 1 to 256
    typedef logic [8:0]  byte_count_t;

    typedef enum logic [2:0] {
        OP_WREN, OP_WRDI, OP_RDSR, OP_PP, OP_SE, OP_BE32, OP_BE64, OP_RDID
    } flash_op_e;

    typedef enum logic [3:0] {
        SEQ_IDLE, SEQ_WEN_START, SEQ_WEN_WAIT, SEQ_GAP_WEN,
        SEQ_CMD_START, SEQ_CMD_WAIT, SEQ_ADDR_START, SEQ_ADDR_WAIT,
        SEQ_DATA_START, SEQ_DATA_WAIT, SEQ_GAP_POLL, SEQ_POLL_CMD,
        SEQ_POLL_CMD_WAIT, SEQ_POLL_READ, SEQ_DONE, SEQ_FAIL
    } seq_state_e;

    typedef enum logic [2:0] {
        SPI_IDLE, SPI_SETUP, SPI_RISE, SPI_HOLD, SPI_FALL
    } spi_state_e;

    typedef struct packed {
        flash_op_e   op;
        flash_addr_t addr;
        byte_count_t count;
    } flash_req_t;

    typedef struct packed {
        flash_byte_t opcode;
        logic        need_wen;
        logic        need_addr;
        logic        need_write_data;
        logic        need_read_data;
        logic        need_poll;
        logic        is_id;
    } op_phases_t;

endpackage

`default_nettype wire

// ==== source/spi_byte_engine.sv ====
// Mode 0 SPI byte shifter, MSB first
`timescale 1ns/1ps
`default_nettype none

module spi_byte_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   spi_start,
    input  flash_pkg::flash_byte_t tx_byte,
    output flash_pkg::flash_byte_t rx_byte,
    output logic                   byte_done,
    output logic                   sck,
    output logic                   mosi,
    input  logic                   miso
);

    import flash_pkg::*;

    spi_state_e  state;
    flash_byte_t tx_shift;
    flash_byte_t rx_shift;
    logic [2:0]  bit_cnt;

    // Four cycles per bit: setup, rise, hold, fall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SPI_IDLE;
            bit_cnt   <= '0;
            sck       <= 1'b0;
            mosi      <= 1'b1;
            byte_done <= 1'b0;
            tx_shift  <= '0;
            rx_shift  <= '0;
            rx_byte   <= '0;
        end else begin
            byte_done <= 1'b0;
            case (state)
                SPI_IDLE: begin
                    sck <= 1'b0;
                    if (spi_start) begin
                        // First bit goes out a full cycle before the edge
                        tx_shift <= tx_byte;
                        mosi     <= tx_byte[7];
                        bit_cnt  <= '0;
                        state    <= SPI_SETUP;
                    end
                end

                SPI_SETUP: begin
                    state <= SPI_RISE;
                end

                SPI_RISE: begin
                    sck      <= 1'b1;
                    rx_shift <= {rx_shift[6:0], miso};
                    state    <= SPI_HOLD;
                end

                SPI_HOLD: begin
                    state <= SPI_FALL;
                end

                SPI_FALL: begin
                    sck     <= 1'b0;
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        rx_byte   <= rx_shift;
                        byte_done <= 1'b1;
                        mosi      <= 1'b1;
                        state     <= SPI_IDLE;
                    end else begin
                        tx_shift <= {tx_shift[6:0], 1'b1};
                        mosi     <= tx_shift[6];
                        state    <= SPI_SETUP;
                    end
                end

                default: state <= SPI_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/flash_op_decoder.sv ====
// Command table: operation to opcode and phase flags
`timescale 1ns/1ps
`default_nettype none
`include "flash_config.svh"

module flash_op_decoder (
    input  flash_pkg::flash_op_e  op,
    output flash_pkg::op_phases_t phases
);

    import flash_pkg::*;

    logic is_erase;
    logic alters_array;

    assign is_erase     = (op == OP_SE) || (op == OP_BE32) || (op == OP_BE64);
    // Program and erases need write enable, an address and polling
    assign alters_array = is_erase || (op == OP_PP);

    always_comb begin
        case (op)
            OP_WREN: phases.opcode = `FLASH_CMD_WREN;
            OP_WRDI: phases.opcode = `FLASH_CMD_WRDI;
            OP_RDSR: phases.opcode = `FLASH_CMD_RDSR1;
            OP_PP:   phases.opcode = `FLASH_CMD_PP;
            OP_SE:   phases.opcode = `FLASH_CMD_SE;
            OP_BE32: phases.opcode = `FLASH_CMD_BE32;
            OP_BE64: phases.opcode = `FLASH_CMD_BE64;
            OP_RDID: phases.opcode = `FLASH_CMD_RDID;
            default: phases.opcode = `FLASH_CMD_RDSR1;
        endcase

        phases.need_wen        = alters_array;
        phases.need_addr       = alters_array;
        phases.need_write_data = (op == OP_PP);
        phases.need_read_data  = (op == OP_RDSR) || (op == OP_RDID);
        phases.need_poll       = alters_array;
        // Three-byte read
        phases.is_id           = (op == OP_RDID);
    end

endmodule

`default_nettype wire

// ==== source/flash_sequencer.sv ====
// Transaction sequencer: write enable, command, address, data,
// chip-select gaps and status polling
`timescale 1ns/1ps
`default_nettype none
`include "flash_config.svh"

module flash_sequencer #(
    parameter int unsigned POLL_LIMIT = `FLASH_POLL_LIMIT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  flash_pkg::flash_req_t  req,
    input  flash_pkg::op_phases_t  phases,
    output flash_pkg::flash_op_e   op,
    input  flash_pkg::flash_byte_t data_in,
    input  logic                   data_valid,
    output logic                   data_req,
    output flash_pkg::flash_byte_t data_out,
    output logic                   data_out_valid,
    output logic                   busy,
    output logic                   done,
    output logic                   error,
    output logic                   ce_n,
    output logic                   spi_start,
    output flash_pkg::flash_byte_t tx_byte,
    input  flash_pkg::flash_byte_t rx_byte,
    input  logic                   byte_done
);

    import flash_pkg::*;

    localparam int PW = $clog2(POLL_LIMIT + 1);
    localparam logic [PW-1:0] POLL_MAX = PW'(POLL_LIMIT);
    localparam logic [3:0] GAP_LAST = 4'(`FLASH_CS_GAP - 1);

    seq_state_e  state;
    flash_req_t  req_q;
    byte_count_t data_cnt;
    byte_count_t xfer_len;
    logic [1:0]  addr_idx;
    logic [3:0]  gap_cnt;
    logic [PW-1:0] poll_cnt;

    assign op = req_q.op;

    // Bytes in the data phase
    always_comb begin
        if (phases.need_write_data) begin
            xfer_len = req_q.count;
        end else if (phases.is_id) begin
            xfer_len = byte_count_t'(`FLASH_ID_BYTES);
        end else begin
            xfer_len = byte_count_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && start) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= SEQ_IDLE;
            ce_n           <= 1'b1;
            spi_start      <= 1'b0;
            tx_byte        <= '0;
            busy           <= 1'b0;
            done           <= 1'b0;
            error          <= 1'b0;
            data_req       <= 1'b0;
            data_out       <= '0;
            data_out_valid <= 1'b0;
            data_cnt       <= '0;
            addr_idx       <= '0;
            gap_cnt        <= '0;
            poll_cnt       <= '0;
        end else begin
            spi_start      <= 1'b0;
            done           <= 1'b0;
            data_out_valid <= 1'b0;

            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        busy     <= 1'b1;
                        error    <= 1'b0;
                        data_cnt <= '0;
                        addr_idx <= '0;
                        poll_cnt <= '0;
                        state    <= SEQ_WEN_START;
                    end
                end

                // ====================
                // Write enable
                // ====================
                SEQ_WEN_START: begin
                    if (phases.need_wen) begin
                        ce_n      <= 1'b0;
                        tx_byte   <= `FLASH_CMD_WREN;
                        spi_start <= 1'b1;
                        state     <= SEQ_WEN_WAIT;
                    end else begin
                        state <= SEQ_CMD_START;
                    end
                end

                SEQ_WEN_WAIT: begin
                    if (byte_done) begin
                        ce_n    <= 1'b1;
                        gap_cnt <= '0;
                        state   <= SEQ_GAP_WEN;
                    end
                end

                // Gap counts with ce_n high, the start state adds one more
                SEQ_GAP_WEN: begin
                    gap_cnt <= gap_cnt + 4'd1;
                    if (gap_cnt == GAP_LAST) begin
                        state <= SEQ_CMD_START;
                    end
                end

                // ====================
                // Command and address
                // ====================
                SEQ_CMD_START: begin
                    ce_n      <= 1'b0;
                    tx_byte   <= phases.opcode;
                    spi_start <= 1'b1;
                    state     <= SEQ_CMD_WAIT;
                end

                SEQ_CMD_WAIT: begin
                    if (byte_done) begin
                        if (phases.need_addr) begin
                            state <= SEQ_ADDR_START;
                        end else if (phases.need_read_data) begin
                            state <= SEQ_DATA_START;
                        end else begin
                            ce_n  <= 1'b1;
                            state <= SEQ_DONE;
                        end
                    end
                end

                SEQ_ADDR_START: begin
                    case (addr_idx)
                        2'd0:    tx_byte <= req_q.addr[23:16];
                        2'd1:    tx_byte <= req_q.addr[15:8];
                        default: tx_byte <= req_q.addr[7:0];
                    endcase
                    spi_start <= 1'b1;
                    state     <= SEQ_ADDR_WAIT;
                end

                SEQ_ADDR_WAIT: begin
                    if (byte_done) begin
                        addr_idx <= addr_idx + 2'd1;
                        if (addr_idx != 2'd2) begin
                            state <= SEQ_ADDR_START;
                        end else if (phases.need_write_data) begin
                            data_req <= 1'b1;
                            state    <= SEQ_DATA_START;
                        end else begin
                            ce_n    <= 1'b1;
                            gap_cnt <= '0;
                            state   <= SEQ_GAP_POLL;
                        end
                    end
                end

                // ====================
                // Data phase
                // ====================
                SEQ_DATA_START: begin
                    if (!phases.need_write_data) begin
                        tx_byte   <= `FLASH_DUMMY_BYTE;
                        spi_start <= 1'b1;
                        state     <= SEQ_DATA_WAIT;
                    end else if (data_valid) begin
                        // Host byte taken, request drops
                        tx_byte   <= data_in;
                        spi_start <= 1'b1;
                        data_req  <= 1'b0;
                        state     <= SEQ_DATA_WAIT;
                    end
                end

                SEQ_DATA_WAIT: begin
                    if (byte_done) begin
                        data_cnt <= data_cnt + 9'd1;
                        if (phases.need_read_data) begin
                            data_out       <= rx_byte;
                            data_out_valid <= 1'b1;
                        end
                        if (data_cnt + 9'd1 == xfer_len) begin
                            ce_n    <= 1'b1;
                            gap_cnt <= '0;
                            state   <= phases.need_poll ? SEQ_GAP_POLL : SEQ_DONE;
                        end else begin
                            data_req <= phases.need_write_data;
                            state    <= SEQ_DATA_START;
                        end
                    end
                end

                // ====================
                // Status polling
                // ====================
                SEQ_GAP_POLL: begin
                    gap_cnt <= gap_cnt + 4'd1;
                    if (gap_cnt == GAP_LAST) begin
                        state <= SEQ_POLL_CMD;
                    end
                end

                SEQ_POLL_CMD: begin
                    ce_n      <= 1'b0;
                    tx_byte   <= `FLASH_CMD_RDSR1;
                    spi_start <= 1'b1;
                    state     <= SEQ_POLL_CMD_WAIT;
                end

                SEQ_POLL_CMD_WAIT: begin
                    if (byte_done) begin
                        tx_byte   <= `FLASH_DUMMY_BYTE;
                        spi_start <= 1'b1;
                        state     <= SEQ_POLL_READ;
                    end
                end

                // Bit 0 of status is write in progress
                SEQ_POLL_READ: begin
                    if (byte_done) begin
                        ce_n <= 1'b1;
                        if (!rx_byte[0]) begin
                            state <= SEQ_DONE;
                        end else if (poll_cnt == POLL_MAX) begin
                            state <= SEQ_FAIL;
                        end else begin
                            poll_cnt <= poll_cnt + 1'b1;
                            gap_cnt  <= '0;
                            state    <= SEQ_GAP_POLL;
                        end
                    end
                end

                SEQ_DONE: begin
                    ce_n  <= 1'b1;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= SEQ_IDLE;
                end

                // Timeout ends with error raised alongside done
                SEQ_FAIL: begin
                    ce_n  <= 1'b1;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    error <= 1'b1;
                    state <= SEQ_IDLE;
                end

                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/flash_programmer.sv ====
// Flash programmer top: decoder, sequencer and SPI byte engine
`timescale 1ns/1ps
`default_nettype none
`include "flash_config.svh"

module flash_programmer #(
    parameter int unsigned POLL_LIMIT = `FLASH_POLL_LIMIT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  flash_pkg::flash_req_t  req,
    input  flash_pkg::flash_byte_t data_in,
    input  logic                   data_valid,
    output logic                   data_req,
    output flash_pkg::flash_byte_t data_out,
    output logic                   data_out_valid,
    output logic                   busy,
    output logic                   done,
    output logic                   error,
    output logic                   sck,
    output logic                   ce_n,
    output logic                   mosi,
    input  logic                   miso
);

    import flash_pkg::*;

    flash_op_e   op;
    op_phases_t  phases;
    logic        spi_start;
    logic        byte_done;
    logic        engine_sck;
    flash_byte_t tx_byte;
    flash_byte_t rx_byte;

    // No clock reaches the flash while deselected
    assign sck = engine_sck & ~ce_n;

    flash_op_decoder u_decoder (
        .op     (op),
        .phases (phases)
    );

    flash_sequencer #(
        .POLL_LIMIT (POLL_LIMIT)
    ) u_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .req            (req),
        .phases         (phases),
        .op             (op),
        .data_in        (data_in),
        .data_valid     (data_valid),
        .data_req       (data_req),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .busy           (busy),
        .done           (done),
        .error          (error),
        .ce_n           (ce_n),
        .spi_start      (spi_start),
        .tx_byte        (tx_byte),
        .rx_byte        (rx_byte),
        .byte_done      (byte_done)
    );

    spi_byte_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .spi_start (spi_start),
        .tx_byte   (tx_byte),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .sck       (engine_sck),
        .mosi      (mosi),
        .miso      (miso)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_flash_model.sv ====
// Behavioral SPI NOR flash: records received bytes, answers
// status and JEDEC ID reads, reports busy after program or erase
`timescale 1ns/1ps
`default_nettype none

module tb_flash_model #(
    parameter logic [7:0] STATUS_IDLE = 8'h1C
) (
    input  logic sck,
    input  logic ce_n,
    input  logic mosi,
    output logic miso,
    input  int   busy_reads
);

    import flash_pkg::*;

    // Bytes seen while selected and a flag for each transaction start
    flash_byte_t rec_byte [0:255];
    logic        rec_first [0:255];
    int          rec_cnt = 0;

    int          txn_cnt = 0;
    int          seen_txn = 0;
    int          byte_idx = 0;
    int          busy_left = 0;
    logic [2:0]  bit_cnt = 3'd0;
    flash_byte_t shift_in = 8'h00;
    flash_byte_t cur_cmd = 8'h00;
    flash_byte_t status_now = 8'h00;
    flash_byte_t resp_byte = 8'hFF;
    logic        miso_q = 1'b1;

    assign miso = miso_q;

    // Byte returned in position idx of the current transaction
    function automatic flash_byte_t response(input int idx);
        flash_byte_t b;
        b = 8'hFF;
        if (cur_cmd == 8'h05) begin
            b = status_now;
        end else if (cur_cmd == 8'h9F) begin
            case (idx)
                1:       b = 8'hEF;
                2:       b = 8'h40;
                3:       b = 8'h18;
                default: b = 8'hFF;
            endcase
        end
        return b;
    endfunction

    always @(negedge ce_n) begin
        txn_cnt = txn_cnt + 1;
    end

    // Sample mosi on the rising edge
    always @(posedge sck) begin
        if (!ce_n) begin
            if (seen_txn != txn_cnt) begin
                seen_txn = txn_cnt;
                bit_cnt  = 3'd0;
                byte_idx = 0;
            end
            shift_in = {shift_in[6:0], mosi};
            bit_cnt  = bit_cnt + 3'd1;
            if (bit_cnt == 3'd0) begin
                rec_byte[rec_cnt]  = shift_in;
                rec_first[rec_cnt] = (byte_idx == 0);
                rec_cnt            = rec_cnt + 1;
                if (byte_idx == 0) begin
                    cur_cmd = shift_in;
                    // Program and erases start the busy period
                    if (shift_in == 8'h02 || shift_in == 8'h20 ||
                        shift_in == 8'h52 || shift_in == 8'hD8) begin
                        busy_left = busy_reads;
                    end
                    if (shift_in == 8'h05) begin
                        status_now = (busy_left != 0) ? (STATUS_IDLE | 8'h01) : STATUS_IDLE;
                        if (busy_left > 0) begin
                            busy_left = busy_left - 1;
                        end
                    end
                end
                byte_idx = byte_idx + 1;
            end
        end
    end

    // Next bit goes out on the falling edge
    always @(negedge sck) begin
        resp_byte = response(byte_idx);
        miso_q    = resp_byte[3'd7 - bit_cnt];
    end

endmodule

`default_nettype wire

// ==== testbench/tb_flash_programmer.sv ====
// Testbench for the flash programmer: clock, reset, stimulus table,
// compare tasks and a cycle-limit watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_flash_programmer;

    import flash_pkg::*;

    localparam int          NUM_TESTS   = 10;
    localparam int          POLL_LIMIT  = 3;
    localparam flash_byte_t STATUS_BYTE = 8'h1C;

    typedef struct packed {
        flash_req_t  req;
        int          busy_polls;   // Negative keeps the flash busy
        logic [39:0] head;         // Leading bytes, first one on top
        int          head_len;
        logic [4:0]  head_first;
        int          polls;
        logic [23:0] rd;
        int          rd_len;
        logic        exp_error;
    } test_entry_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    flash_req_t  req;
    flash_byte_t data_in;
    logic        data_valid;
    logic        data_req;
    flash_byte_t data_out;
    logic        data_out_valid;
    logic        busy;
    logic        done;
    logic        error;
    logic        sck;
    logic        ce_n;
    logic        mosi;
    logic        miso;
    int          busy_reads;

    string       test_name [0:NUM_TESTS-1];
    test_entry_t entries [0:NUM_TESTS-1];
    int          num_entries = 0;
    int          seed = 32'h7583d4b9;
    int          error_count = 0;
    int          failed_tests = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    int          i;

    flash_programmer #(
        .POLL_LIMIT (POLL_LIMIT)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .req            (req),
        .data_in        (data_in),
        .data_valid     (data_valid),
        .data_req       (data_req),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .busy           (busy),
        .done           (done),
        .error          (error),
        .sck            (sck),
        .ce_n           (ce_n),
        .mosi           (mosi),
        .miso           (miso)
    );

    tb_flash_model #(
        .STATUS_IDLE (STATUS_BYTE)
    ) flash (
        .sck        (sck),
        .ce_n       (ce_n),
        .mosi       (mosi),
        .miso       (miso),
        .busy_reads (busy_reads)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: no end of the test sequence after %0d cycles", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // ====================
    // Compare tasks
    // ====================
    task automatic check_byte(input string test, input string what,
                              input flash_byte_t exp, input flash_byte_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %b, actual %b", test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_count(input string test, input string what,
                               input int exp, input int act);
        if (exp != act) begin
            $display("ERR %s %s: expected %0d, actual %0d", test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s", name);
            failed_tests++;
        end
    endtask

    // ====================
    // Stimulus table
    // ====================
    task automatic add_entry(input string name, input flash_op_e op, input flash_addr_t addr,
                             input byte_count_t count, input int busy_cnt,
                             input logic [39:0] head, input int head_len,
                             input logic [4:0] first, input int polls,
                             input logic [23:0] rd, input int rd_len, input logic err);
        test_entry_t e;
        e            = '0;
        e.req.op     = op;
        e.req.addr   = addr;
        e.req.count  = count;
        e.busy_polls = busy_cnt;
        e.head       = head;
        e.head_len   = head_len;
        e.head_first = first;
        e.polls      = polls;
        e.rd         = rd;
        e.rd_len     = rd_len;
        e.exp_error  = err;
        test_name[num_entries] = name;
        entries[num_entries]   = e;
        num_entries++;
        // About 200 cycles for each byte on the wire
        cycle_limit = cycle_limit + 200 * (head_len + int'(count) + 2 * polls);
    endtask

    task automatic check_reset_values;
        int errs_before;
        errs_before = error_count;
        check_flag("reset_values", "ce_n", 1'b1, ce_n);
        check_flag("reset_values", "sck", 1'b0, sck);
        check_flag("reset_values", "mosi", 1'b1, mosi);
        check_flag("reset_values", "busy", 1'b0, busy);
        check_flag("reset_values", "done", 1'b0, done);
        check_flag("reset_values", "error", 1'b0, error);
        check_flag("reset_values", "data_req", 1'b0, data_req);
        check_flag("reset_values", "data_out_valid", 1'b0, data_out_valid);
        report_test("reset_values", errs_before);
    endtask

    task automatic run_test(input int t);
        test_entry_t e;
        flash_byte_t sent_q[$];
        flash_byte_t got_q[$];
        flash_byte_t exp_b;
        logic        exp_f;
        logic        err_seen;
        logic        busy_seen;
        logic        busy_high;
        logic        finished;
        logic [39:0] head;
        logic [4:0]  first;
        logic [23:0] rd;
        int          errs_before;
        int          base;
        int          actual;
        int          exp_n;
        int          waited;
        int          delay;
        int          rnd;
        int          j;
        int          k;

        e           = entries[t];
        errs_before = error_count;
        base        = flash.rec_cnt;
        head        = e.head;
        first       = e.head_first;
        rd          = e.rd;
        err_seen    = 1'b0;
        busy_seen   = 1'b0;
        busy_high   = 1'b0;
        finished    = 1'b0;
        waited      = 0;
        delay       = {$random(seed)} % 6;

        @(posedge clk);
        req        <= e.req;
        busy_reads <= e.busy_polls;
        start      <= 1'b1;
        @(posedge clk);
        start      <= 1'b0;

        // Feed page bytes and collect read bytes until done
        while (!finished) begin
            @(posedge clk);
            if (busy) begin
                busy_high = 1'b1;
            end
            if (data_out_valid) begin
                got_q.push_back(data_out);
            end
            if (data_req && data_valid) begin
                data_valid <= 1'b0;
                waited     = 0;
                delay      = {$random(seed)} % 6;
            end else if (data_req) begin
                if (waited >= delay) begin
                    rnd        = $random(seed);
                    data_in    <= rnd[7:0];
                    data_valid <= 1'b1;
                    sent_q.push_back(rnd[7:0]);
                end else begin
                    waited++;
                end
            end
            if (done) begin
                err_seen  = error;
                busy_seen = busy;
                finished  = 1'b1;
            end
        end

        check_flag(test_name[t], "error", e.exp_error, err_seen);
        check_flag(test_name[t], "busy during operation", 1'b1, busy_high);
        check_flag(test_name[t], "busy at done", 1'b0, busy_seen);
        check_count(test_name[t], "host bytes", int'(e.req.count), sent_q.size());
        exp_n  = e.head_len + sent_q.size() + 2 * e.polls;
        actual = flash.rec_cnt - base;
        check_count(test_name[t], "flash bytes", exp_n, actual);
        for (k = 0; k < exp_n && k < actual; k++) begin
            if (k < e.head_len) begin
                exp_b = head[39:32];
                exp_f = first[4];
                head  = head << 8;
                first = first << 1;
            end else if (k < e.head_len + sent_q.size()) begin
                exp_b = sent_q[k - e.head_len];
                exp_f = 1'b0;
            end else begin
                // Each poll is the status opcode and one dummy byte
                j     = k - e.head_len - sent_q.size();
                exp_b = (j % 2 == 0) ? 8'h05 : 8'hFF;
                exp_f = (j % 2 == 0);
            end
            check_byte(test_name[t], $sformatf("flash byte %0d", k), exp_b,
                       flash.rec_byte[base + k]);
            check_flag(test_name[t], $sformatf("transaction start at byte %0d", k), exp_f,
                       flash.rec_first[base + k]);
        end

        check_count(test_name[t], "read bytes", e.rd_len, got_q.size());
        for (k = 0; k < e.rd_len && k < got_q.size(); k++) begin
            check_byte(test_name[t], $sformatf("read byte %0d", k), rd[23:16], got_q[k]);
            rd = rd << 8;
        end
        report_test(test_name[t], errs_before);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        req        = '0;
        data_in    = '0;
        data_valid = 1'b0;
        busy_reads = 0;

        add_entry("write_enable", OP_WREN, 24'h000000, 9'd0, 0,
                  40'h06_00_00_00_00, 1, 5'b10000, 0, 24'h000000, 0, 1'b0);
        add_entry("write_disable", OP_WRDI, 24'h000000, 9'd0, 0,
                  40'h04_00_00_00_00, 1, 5'b10000, 0, 24'h000000, 0, 1'b0);
        add_entry("read_status", OP_RDSR, 24'h000000, 9'd0, 0,
                  40'h05_FF_00_00_00, 2, 5'b10000, 0, {STATUS_BYTE, 16'h0000}, 1, 1'b0);
        add_entry("read_id", OP_RDID, 24'h000000, 9'd0, 0,
                  40'h9F_FF_FF_FF_00, 4, 5'b10000, 0, 24'hEF4018, 3, 1'b0);
        add_entry("page_program", OP_PP, 24'h123400, 9'd5, 2,
                  40'h06_02_12_34_00, 5, 5'b11000, 3, 24'h000000, 0, 1'b0);
        add_entry("sector_erase", OP_SE, 24'h001000, 9'd0, 1,
                  40'h06_20_00_10_00, 5, 5'b11000, 2, 24'h000000, 0, 1'b0);
        add_entry("block_erase_32k", OP_BE32, 24'h018000, 9'd0, 0,
                  40'h06_52_01_80_00, 5, 5'b11000, 1, 24'h000000, 0, 1'b0);
        add_entry("block_erase_64k", OP_BE64, 24'h3F0000, 9'd0, 3,
                  40'h06_D8_3F_00_00, 5, 5'b11000, 4, 24'h000000, 0, 1'b0);
        add_entry("poll_timeout", OP_SE, 24'h002000, 9'd0, -1,
                  40'h06_20_00_20_00, 5, 5'b11000, POLL_LIMIT + 1, 24'h000000, 0, 1'b1);
        add_entry("write_enable_after_timeout", OP_WREN, 24'h000000, 9'd0, 0,
                  40'h06_00_00_00_00, 1, 5'b10000, 0, 24'h000000, 0, 1'b0);

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_values();

        for (i = 0; i < num_entries; i++) begin
            run_test(i);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors", num_entries + 1,
                 num_entries + 1 - failed_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/flash_pkg.sv
source/spi_byte_engine.sv
source/flash_op_decoder.sv
source/flash_sequencer.sv
source/flash_programmer.sv
testbench/tb_flash_model.sv
testbench/tb_flash_programmer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the flash programmer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_flash_programmer
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_flash_programmer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
